/* include/secded_funcs.svh */
`ifndef SECDED_FUNCS_SVH
`define SECDED_FUNCS_SVH

// hamming positions 1..21 live in word[20:0], overall parity in the msb.
// check bits sit on the power-of-two positions, data fills the rest.
localparam int SECDED_NPOS = PHYWDTH - 1;   // positions covered by hamming.
localparam int SECDED_NHAM = ECCBITS - 1;   // hamming check bits.

// spread data over the non power-of-two positions, then fill in parity.
function automatic code_t secded_encode(input data_t data);
  code_t word;
  int    d;
  logic  par;
  word = '0;
  d    = 0;
  for (int pos = 1; pos <= SECDED_NPOS; pos++) begin
    if ((pos & (pos - 1)) != 0) begin   // not a check position.
      word[pos-1] = data[d];
      d++;
    end
  end
  for (int k = 0; k < SECDED_NHAM; k++) begin
    par = 1'b0;
    for (int pos = 1; pos <= SECDED_NPOS; pos++) begin
      if (pos[k])
        par ^= word[pos-1];   // check slots still zero here.
    end
    word[(1 << k) - 1] = par;
  end
  word[PHYWDTH-1] = ^word[PHYWDTH-2:0];   // overall even parity.
  return word;
endfunction

// syndrome, msb is the overall parity mismatch.
// low bits give the hamming position of a single flipped bit.
function automatic logic [ECCBITS-1:0] secded_check(input code_t word);
  logic [ECCBITS-1:0] syn;
  syn = '0;
  for (int k = 0; k < SECDED_NHAM; k++) begin
    for (int pos = 1; pos <= SECDED_NPOS; pos++) begin
      if (pos[k])
        syn[k] ^= word[pos-1];
    end
  end
  syn[ECCBITS-1] = ^word;   // zero on a clean word.
  return syn;
endfunction

// pull the data bits back out of a stored word.
function automatic data_t secded_data(input code_t word);
  data_t data;
  int    d;
  data = '0;
  d    = 0;
  for (int pos = 1; pos <= SECDED_NPOS; pos++) begin
    if ((pos & (pos - 1)) != 0) begin
      data[d] = word[pos-1];
      d++;
    end
  end
  return data;
endfunction

`endif

/* src/mem_pkg.sv */
package mem_pkg;

  // default geometry, overridden from the top level.
  localparam int WIDTH      = 16;   // user data bits.
  localparam int NUMVBNK    = 4;    // banks.
  localparam int BITVBNK    = 2;
  localparam int NUMSROW    = 64;   // rows per bank.
  localparam int BITSROW    = 6;
  localparam int SRAM_DELAY = 1;    // bank read latency.

  // 5 hamming bits plus overall parity.
  localparam int ECCBITS = 6;
  localparam int PHYWDTH = WIDTH + ECCBITS;   // stored word.
  localparam int BITADDR = BITVBNK + BITSROW;
  localparam int BITPADR = BITVBNK + BITSROW;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [PHYWDTH-1:0] code_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVBNK-1:0] bank_t;
  typedef logic [BITSROW-1:0] row_t;
  typedef logic [BITPADR-1:0] padr_t;   // {row, bank}.

  // decode to execute.
  typedef struct packed {
    logic  wr;
    logic  rd;
    bank_t bank;
    row_t  row;
    code_t word;   // encoded write data.
  } cmd_t;

  // read tag, follows the bank latency.
  typedef struct packed {
    logic  vld;
    bank_t bank;
    row_t  row;
  } rsp_t;

  typedef enum logic [1:0] {
    INIT_RST,
    INIT_CLEAR,   // walking the rows.
    INIT_DONE
  } init_state_t;

`include "secded_funcs.svh"

endpackage

/* src/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode #(
  parameter int WIDTH   = mem_pkg::WIDTH,
  parameter int NUMVBNK = mem_pkg::NUMVBNK,
  parameter int NUMSROW = mem_pkg::NUMSROW
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            ru_write,
  input  logic            ru_read,
  input  mem_pkg::addr_t  ru_addr,
  input  mem_pkg::data_t  ru_din,
  output logic            ready,
  output mem_pkg::cmd_t   cmd,
  output logic            clr
);
  import mem_pkg::*;

  localparam int BNKW = $clog2(NUMVBNK);   // low address bits pick the bank.

  logic        rst_meta_n;
  logic        rst_n;   // synchronized reset.
  init_state_t state;
  row_t        clr_row;
  logic        last_row;
  logic        clearing;

  bank_t bank_d;
  row_t  row_d;
  code_t word_d;

  logic  wr_q;
  logic  rd_q;
  logic  clr_q;
  bank_t bank_q;
  row_t  row_q;
  code_t word_q;

  // assert async, release on the clock.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_meta_n <= 1'b0;
      rst_n      <= 1'b0;
    end else begin
      rst_meta_n <= 1'b1;
      rst_n      <= rst_meta_n;
    end
  end

  assign last_row = (clr_row == row_t'(NUMSROW - 1));
  assign clearing = (state == INIT_CLEAR);
  assign ready    = (state == INIT_DONE);

  // init walks every row once, all banks in parallel.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= INIT_RST;
      clr_row <= '0;
    end else begin
      case (state)
        INIT_RST: state <= INIT_CLEAR;
        INIT_CLEAR: begin
          clr_row <= clr_row + 1'b1;
          if (last_row)
            state <= INIT_DONE;   // ready next cycle.
        end
        INIT_DONE: state <= INIT_DONE;
        default: state <= INIT_RST;
      endcase
    end
  end

  // address split and encode, or the clear word during init.
  always_comb begin
    if (clearing) begin
      bank_d = '0;   // clr fans out to every bank.
      row_d  = clr_row;
      word_d = secded_encode('0);
    end else begin
      bank_d = ru_addr[BNKW-1:0];
      row_d  = ru_addr[BITADDR-1:BNKW];
      word_d = secded_encode(ru_din[WIDTH-1:0]);
    end
  end

  // strobes, user commands only once ready.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_q  <= 1'b0;
      rd_q  <= 1'b0;
      clr_q <= 1'b0;
    end else begin
      wr_q  <= clearing | (ready & ru_write);
      rd_q  <= ready & ru_read;
      clr_q <= clearing;
    end
  end

  always_ff @(posedge clk) begin
    bank_q <= bank_d;
    row_q  <= row_d;
    word_q <= word_d;
  end

  assign cmd = '{wr: wr_q, rd: rd_q, bank: bank_q, row: row_q, word: word_q};
  assign clr = clr_q;

  // single port, one op per cycle.
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ru_write && ru_read))
    else $error("read and write in the same cycle");

  // host must wait for init to finish.
  a_no_cmd_early: assert property (@(posedge clk) disable iff (!rst_n)
    !ready |-> !(ru_write || ru_read))
    else $error("command issued before ready");

endmodule

/* src/bank_access.sv */
`timescale 1ns/1ps

module bank_access #(
  parameter int NUMVBNK    = mem_pkg::NUMVBNK,
  parameter int SRAM_DELAY = mem_pkg::SRAM_DELAY
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  mem_pkg::cmd_t                 cmd,
  input  logic                          clr,
  output logic [NUMVBNK-1:0]            t1_write_a,
  output mem_pkg::row_t  [NUMVBNK-1:0]  t1_addr_a,
  output mem_pkg::code_t [NUMVBNK-1:0]  t1_din_a,
  output logic [NUMVBNK-1:0]            t1_read_b,
  output mem_pkg::row_t  [NUMVBNK-1:0]  t1_addr_b,
  output mem_pkg::rsp_t                 tag
);
  import mem_pkg::*;

  // one stage into the bank, SRAM_DELAY inside it.
  localparam int STAGES = SRAM_DELAY + 1;

  logic [STAGES-1:0] vld_pipe;
  bank_t             bank_pipe [STAGES];
  row_t              row_pipe  [STAGES];

  // bank decode, port strobes follow cmd directly.
  always_comb begin
    for (int b = 0; b < NUMVBNK; b++) begin
      t1_write_a[b] = cmd.wr & (clr | (cmd.bank == bank_t'(b)));
      t1_addr_a[b]  = cmd.row;
      t1_din_a[b]   = cmd.word;
      t1_read_b[b]  = cmd.rd & (cmd.bank == bank_t'(b));   // reads never broadcast.
      t1_addr_b[b]  = cmd.row;
    end
  end

  // tag valid bits.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= cmd.rd;
      for (int i = 1; i < STAGES; i++)
        vld_pipe[i] <= vld_pipe[i-1];
    end
  end

  // bank and row ride along with the valid.
  always_ff @(posedge clk) begin
    bank_pipe[0] <= cmd.bank;
    row_pipe[0]  <= cmd.row;
    for (int i = 1; i < STAGES; i++) begin
      bank_pipe[i] <= bank_pipe[i-1];
      row_pipe[i]  <= row_pipe[i-1];
    end
  end

  // lines up with t1_dout_b.
  assign tag = '{vld: vld_pipe[STAGES-1], bank: bank_pipe[STAGES-1], row: row_pipe[STAGES-1]};

  // single port, at most one bank strobe per cycle outside init.
  a_rd_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    !clr |-> $onehot0({t1_read_b, t1_write_a}))
    else $error("more than one bank strobe outside init");

endmodule

/* src/read_result.sv */
`timescale 1ns/1ps

module read_result #(
  parameter int NUMVBNK = mem_pkg::NUMVBNK
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  mem_pkg::rsp_t                 tag,
  input  mem_pkg::code_t [NUMVBNK-1:0]  t1_dout_b,
  output logic                          ru_vld,
  output mem_pkg::data_t                ru_dout,
  output logic                          ru_serr,
  output logic                          ru_derr,
  output mem_pkg::padr_t                ru_padr
);
  import mem_pkg::*;

  code_t              raw;
  code_t              fixed;
  logic [ECCBITS-1:0] syn;
  logic [ECCBITS-2:0] pos;   // hamming position of the bad bit.
  logic               par_err;
  logic               single;
  logic               double;

  assign raw     = t1_dout_b[tag.bank];   // tagged bank only.
  assign syn     = secded_check(raw);
  assign pos     = syn[ECCBITS-2:0];
  assign par_err = syn[ECCBITS-1];

  // classify and correct.
  always_comb begin
    fixed  = raw;
    single = 1'b0;
    double = 1'b0;
    if (par_err) begin
      if (pos == '0) begin
        fixed[PHYWDTH-1] = ~raw[PHYWDTH-1];   // overall parity bit itself.
        single           = 1'b1;
      end else if (int'(pos) <= SECDED_NPOS) begin
        fixed  = raw ^ (code_t'(1) << (pos - 1'b1));   // data or check bit.
        single = 1'b1;
      end else begin
        double = 1'b1;   // points past the word, not correctable.
      end
    end else if (pos != '0) begin
      double = 1'b1;   // parity fine but syndrome set, two bits flipped.
    end
  end

  // flags and valid.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ru_vld  <= 1'b0;
      ru_serr <= 1'b0;
      ru_derr <= 1'b0;
    end else begin
      ru_vld  <= tag.vld;
      ru_serr <= tag.vld & single;
      ru_derr <= tag.vld & double;
    end
  end

  // payload, held between reads.
  always_ff @(posedge clk) begin
    if (tag.vld) begin
      ru_dout <= secded_data(fixed);   // raw bits on a double error.
      ru_padr <= {tag.row, tag.bank};
    end
  end

  // a corrected word checks clean.
  a_fix_clean: assert property (@(posedge clk) disable iff (!arst_n)
    (tag.vld && single) |-> (secded_check(fixed) == '0))
    else $error("corrected word still has a syndrome");

endmodule

/* src/banked_mem_top.sv */
`timescale 1ns/1ps

module banked_mem_top #(
  parameter int WIDTH      = mem_pkg::WIDTH,
  parameter int NUMVBNK    = mem_pkg::NUMVBNK,
  parameter int NUMSROW    = mem_pkg::NUMSROW,
  parameter int SRAM_DELAY = mem_pkg::SRAM_DELAY
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          ru_write,
  input  logic                          ru_read,
  input  mem_pkg::addr_t                ru_addr,
  input  mem_pkg::data_t                ru_din,
  output logic                          ready,
  output logic                          ru_vld,
  output mem_pkg::data_t                ru_dout,
  output logic                          ru_serr,
  output logic                          ru_derr,
  output mem_pkg::padr_t                ru_padr,
  output logic [NUMVBNK-1:0]            t1_write_a,   // bank port a, writes.
  output mem_pkg::row_t  [NUMVBNK-1:0]  t1_addr_a,
  output mem_pkg::code_t [NUMVBNK-1:0]  t1_din_a,
  output logic [NUMVBNK-1:0]            t1_read_b,    // bank port b, reads.
  output mem_pkg::row_t  [NUMVBNK-1:0]  t1_addr_b,
  input  mem_pkg::code_t [NUMVBNK-1:0]  t1_dout_b
);
  import mem_pkg::*;

  cmd_t cmd;
  logic clr;
  rsp_t tag;

  // decode, init and command register.
  cmd_decode #(
    .WIDTH   (WIDTH),
    .NUMVBNK (NUMVBNK),
    .NUMSROW (NUMSROW)
  ) u_decode (
    .clk      (clk),
    .arst_n   (arst_n),
    .ru_write (ru_write),
    .ru_read  (ru_read),
    .ru_addr  (ru_addr),
    .ru_din   (ru_din),
    .ready    (ready),
    .cmd      (cmd),
    .clr      (clr)
  );

  bank_access #(
    .NUMVBNK    (NUMVBNK),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_access (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd        (cmd),
    .clr        (clr),
    .t1_write_a (t1_write_a),
    .t1_addr_a  (t1_addr_a),
    .t1_din_a   (t1_din_a),
    .t1_read_b  (t1_read_b),
    .t1_addr_b  (t1_addr_b),
    .tag        (tag)
  );

  // ecc check and output register.
  read_result #(
    .NUMVBNK (NUMVBNK)
  ) u_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .tag       (tag),
    .t1_dout_b (t1_dout_b),
    .ru_vld    (ru_vld),
    .ru_dout   (ru_dout),
    .ru_serr   (ru_serr),
    .ru_derr   (ru_derr),
    .ru_padr   (ru_padr)
  );

endmodule

/* verification/sram_bank_model.sv */
`timescale 1ns/1ps

module sram_bank_model #(
  parameter int NUMSROW = mem_pkg::NUMSROW,
  parameter int DELAY   = mem_pkg::SRAM_DELAY
) (
  input  logic           clk,
  input  logic           write_a,
  input  mem_pkg::row_t  addr_a,
  input  mem_pkg::code_t din_a,
  input  logic           read_b,
  input  mem_pkg::row_t  addr_b,
  output mem_pkg::code_t dout_b
);
  import mem_pkg::*;

  code_t mem [NUMSROW];
  code_t rd_pipe [DELAY+1];   // [0] takes the read, the rest is latency.
  logic  flip_req = 1'b0;
  row_t  flip_row;
  code_t flip_mask;

  // port a writes, port b reads the old content on a collision.
  always @(posedge clk) begin
    if (write_a)
      mem[addr_a] <= din_a;
    if (flip_req)
      mem[flip_row] <= mem[flip_row] ^ flip_mask;   // injected error.
    if (read_b)
      rd_pipe[0] <= mem[addr_b];
    for (int i = 1; i <= DELAY; i++)
      rd_pipe[i] <= rd_pipe[i-1];
  end

  assign dout_b = rd_pipe[DELAY];

  // flips the masked bits of one stored word on the next edge.
  task automatic flip_bits(input row_t row, input code_t mask);
    flip_row  <= row;
    flip_mask <= mask;
    flip_req  <= 1'b1;
    @(posedge clk);
    flip_req  <= 1'b0;
  endtask

endmodule

/* verification/tb_banked_mem.sv */
`timescale 1ns/1ps

module tb_banked_mem;
  import mem_pkg::*;

  parameter int SEED = 51;
  localparam int N_RAND = 40;
  localparam int RD_LAT = 5;   // drive edge to ru_vld, seen at the negedge.

  typedef enum logic [2:0] {OP_IDLE, OP_WRITE, OP_READ, OP_INJ1, OP_INJ2} op_t;
  typedef struct packed {
    op_t        op;
    addr_t      addr;
    data_t      data;    // write data, or code bit indices for an inject.
    logic [1:0] flags;   // expected {derr, serr}.
  } step_t;
  typedef struct packed {
    int         due;
    data_t      data;
    padr_t      padr;
    logic [1:0] flags;
    logic       chk_data;
  } exp_t;

  logic                clk;
  logic                arst_n;
  logic                ru_write;
  logic                ru_read;
  addr_t               ru_addr;
  data_t               ru_din;
  logic                ready;
  logic                ru_vld;
  data_t               ru_dout;
  logic                ru_serr;
  logic                ru_derr;
  padr_t               ru_padr;
  logic [NUMVBNK-1:0]  t1_write_a;
  row_t [NUMVBNK-1:0]  t1_addr_a;
  code_t [NUMVBNK-1:0] t1_din_a;
  logic [NUMVBNK-1:0]  t1_read_b;
  row_t [NUMVBNK-1:0]  t1_addr_b;
  code_t [NUMVBNK-1:0] t1_dout_b;

  step_t              steps[$];
  exp_t               exp_q[$];   // reads in flight.
  data_t              shadow [256];
  logic [NUMSROW-1:0] rows_seen = '0;
  int cyc       = 0;
  int clr_cnt   = 0;
  int err_val   = 0;
  int err_other = 0;
  int limit     = 0;
  int seed;

  banked_mem_top dut (.*);

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    sram_bank_model #(.NUMSROW(NUMSROW), .DELAY(SRAM_DELAY)) u_bank (
      .clk(clk), .write_a(t1_write_a[b]), .addr_a(t1_addr_a[b]), .din_a(t1_din_a[b]),
      .read_b(t1_read_b[b]), .addr_b(t1_addr_b[b]), .dout_b(t1_dout_b[b]));
  end

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want)
    else begin
      err_val++;
      $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, want);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else begin
      err_other++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  task automatic add_step(input op_t op, input addr_t a, input data_t d, input logic [1:0] f);
    steps.push_back('{op, a, d, f});
  endtask

  // one or two code bits, indices in data[4:0] and data[12:8].
  function automatic code_t bit_mask(input data_t idx, input logic two);
    code_t m;
    m = code_t'(1) << idx[4:0];
    if (two)
      m = m | (code_t'(1) << idx[12:8]);
    return m;
  endfunction

  task automatic flip_stored(input addr_t a, input code_t mask);
    case (a[BITVBNK-1:0])   // low bits pick the bank.
      2'd0: g_bank[0].u_bank.flip_bits(a[BITADDR-1:BITVBNK], mask);
      2'd1: g_bank[1].u_bank.flip_bits(a[BITADDR-1:BITVBNK], mask);
      2'd2: g_bank[2].u_bank.flip_bits(a[BITADDR-1:BITVBNK], mask);
      default: g_bank[3].u_bank.flip_bits(a[BITADDR-1:BITVBNK], mask);
    endcase
  endtask

  task automatic apply_step(input step_t s);
    exp_t e;
    @(posedge clk);
    ru_write <= (s.op == OP_WRITE);
    ru_read  <= (s.op == OP_READ);
    ru_addr  <= s.addr;
    ru_din   <= s.data;
    case (s.op)
      OP_WRITE: shadow[s.addr] = s.data;
      OP_READ: begin
        e.due      = cyc + RD_LAT;
        e.data     = shadow[s.addr];
        e.padr     = s.addr;         // {row, bank} matches the address.
        e.flags    = s.flags;
        e.chk_data = !s.flags[1];    // raw bits on derr.
        exp_q.push_back(e);
      end
      OP_INJ1, OP_INJ2: begin
        @(posedge clk);   // a write just before has landed by now.
        flip_stored(s.addr, bit_mask(s.data, s.op == OP_INJ2));
      end
      default: ;
    endcase
  endtask

  always begin : monitor
    exp_t e;
    @(negedge clk);
    if (t1_write_a == '1) begin   // init clear, all banks at once.
      clr_cnt++;
      rows_seen[t1_addr_a[0]] = 1'b1;
      check_value("t1_din_a", 32'(t1_din_a[0]), 32'd0);   // coded zero is all zeros.
      // ready comes up together with the last clear at the banks.
      check_true(ready == (clr_cnt == NUMSROW), "ready not raised with the last init clear");
    end
    if (!arst_n)
      check_true(!ready, "ready high during reset");
    if (!ready) begin
      check_true(!ru_vld && !ru_serr && !ru_derr, "result outputs active before ready");
      check_true(t1_read_b == '0, "bank read strobe before ready");
    end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      check_true(ru_vld, "ru_vld missing at its expected cycle");
      check_value("ru_padr", 32'(ru_padr), 32'(e.padr));
      check_value("ru_serr", 32'(ru_serr), 32'(e.flags[0]));
      check_value("ru_derr", 32'(ru_derr), 32'(e.flags[1]));
      if (e.chk_data)
        check_value("ru_dout", 32'(ru_dout), 32'(e.data));
    end else begin
      check_true(!ru_vld, "ru_vld without a pending read");
    end
  end

  initial begin : watchdog
    wait (limit != 0);
    while (cyc < limit) @(posedge clk);
    $display("timeout after %0d cycles, %0d reads pending", cyc, exp_q.size());
    $display("** FAIL **");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    arst_n   = 1'b0;
    ru_write = 1'b0;
    ru_read  = 1'b0;
    ru_addr  = '0;
    ru_din   = '0;
    seed     = SEED;
    foreach (shadow[i]) shadow[i] = '0;
    add_step(OP_READ,  8'h05, 16'h0000, 2'b00);   // never written.
    add_step(OP_READ,  8'h7e, 16'h0000, 2'b00);
    add_step(OP_WRITE, 8'h10, 16'ha001, 2'b00);   // one per bank.
    add_step(OP_WRITE, 8'h11, 16'hb002, 2'b00);
    add_step(OP_WRITE, 8'h12, 16'hc003, 2'b00);
    add_step(OP_WRITE, 8'h13, 16'hd004, 2'b00);
    add_step(OP_READ,  8'h10, 16'h0000, 2'b00);   // back to back.
    add_step(OP_READ,  8'h11, 16'h0000, 2'b00);
    add_step(OP_READ,  8'h12, 16'h0000, 2'b00);
    add_step(OP_READ,  8'h13, 16'h0000, 2'b00);
    add_step(OP_WRITE, 8'h20, 16'h1234, 2'b00);
    add_step(OP_READ,  8'h20, 16'h0000, 2'b00);   // right after the write.
    add_step(OP_WRITE, 8'h24, 16'h5a5a, 2'b00);
    add_step(OP_INJ1,  8'h24, 16'h0002, 2'b00);   // data bit, position 3.
    add_step(OP_READ,  8'h24, 16'h0000, 2'b01);
    add_step(OP_WRITE, 8'h29, 16'h0f0f, 2'b00);
    add_step(OP_INJ1,  8'h29, 16'h0000, 2'b00);   // check bit, position 1.
    add_step(OP_READ,  8'h29, 16'h0000, 2'b01);
    add_step(OP_WRITE, 8'h2e, 16'hffff, 2'b00);
    add_step(OP_INJ1,  8'h2e, 16'h0015, 2'b00);   // overall parity bit.
    add_step(OP_READ,  8'h2e, 16'h0000, 2'b01);
    add_step(OP_WRITE, 8'h33, 16'h3c3c, 2'b00);
    add_step(OP_INJ2,  8'h33, 16'h0402, 2'b00);   // two data bits.
    add_step(OP_READ,  8'h33, 16'h0000, 2'b10);
    add_step(OP_WRITE, 8'h34, 16'h8001, 2'b00);
    add_step(OP_INJ2,  8'h34, 16'h0100, 2'b00);   // two check bits.
    add_step(OP_READ,  8'h34, 16'h0000, 2'b10);
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);   // upper address range, kept clear of injects.
      add_step(rnd[31] ? OP_WRITE : OP_READ, {3'b100, rnd[4:0]}, rnd[23:8], 2'b00);
    end
    limit = steps.size() + NUMSROW + 50;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    while (!ready) @(negedge clk);
    foreach (steps[i]) apply_step(steps[i]);
    @(posedge clk);
    ru_write <= 1'b0;
    ru_read  <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk);   // drain.
    check_true(clr_cnt == NUMSROW, "wrong number of init clear cycles");
    check_true(&rows_seen, "init did not clear every row");
    $display("summary: %0d value errors, %0d other errors", err_val, err_other);
    if (err_val == 0 && err_other == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* src.f */
+incdir+include
src/mem_pkg.sv
src/cmd_decode.sv
src/bank_access.sv
src/read_result.sv
src/banked_mem_top.sv
verification/sram_bank_model.sv
verification/tb_banked_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_banked_mem
SEED      ?= 51
FILELIST  ?= src.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED FILELIST OBJDIR"

test:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
	  -GSEED=$(SEED) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; \
	  echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJDIR)
